//--- files.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_axil_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
test/uart_tb.sv

//--- test/uart_tb.sv
// ##################################################
// UART testbench
// Directed tests over AXI4-Lite and the serial lines
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;

    localparam int BAUD             = 8;
    localparam int FRAME_COUNT      = 4 * 6 + 4 * 4 + 2 + 8;
    // Start, nine data bits, parity, two stop bits and one idle bit
    localparam int MAX_FRAME_CYCLES = 14 * BAUD;
    localparam int TIMEOUT_CYCLES   = FRAME_COUNT * MAX_FRAME_CYCLES + 3000;

    logic        clk;
    logic        n_reset;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        tx;
    logic        rx;
    logic        cts;
    logic [31:0] rng_state = 32'h6388_df5b;

    uart_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [8:0] random_word();
        logic [31:0] r;
        r = next_random();
        return r[8:0];
    endfunction

    function automatic logic [31:0] make_ctrl(input logic [2:0] data_bits,
                                              input logic [1:0] parity,
                                              input logic [1:0] stop_bits,
                                              input logic flow, input int baud);
        return {data_bits, parity, stop_bits, flow, 24'(baud)};
    endfunction

    // Word length is data_bits + 5, and anything above 4 means nine bits
    function automatic int word_length(input logic [31:0] ctrl);
        return (ctrl[31:29] > 3'd4) ? 9 : int'(ctrl[31:29]) + 5;
    endfunction

    function automatic logic [8:0] word_mask(input logic [31:0] ctrl);
        return 9'((1 << word_length(ctrl)) - 1);
    endfunction

    function automatic logic parity_bit(input logic [31:0] ctrl, input logic [8:0] word);
        logic p;
        int   i;
        p = 1'b0;
        for (i = 0; i < word_length(ctrl); i++)
            p = p ^ word[i];
        return (ctrl[28:27] == `UART_PARITY_ODD) ? !p : p;
    endfunction

    function automatic int stop_cycles(input logic [31:0] ctrl);
        int baud;
        baud = int'(ctrl[23:0]);
        case (ctrl[26:25])
            `UART_STOP_BITS_15: return baud + baud / 2;
            `UART_STOP_BITS_2:  return 2 * baud;
            default:            return baud;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Check failed");
        end
    endtask

    // Every driver task starts and ends 10 ns after a rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        step();
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do
            step();
        while (!(awready && wready));
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_equal("bvalid", bvalid, 1);
        check_equal("bresp", bresp, 0);
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        step();
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready)
            step();
        step();
        arvalid = 1'b0;
        check_equal("rvalid", rvalid, 1);
        check_equal("rresp", rresp, 0);
        data = rdata;
    endtask

    task automatic wait_tx_idle();
        logic [31:0] status;
        status = 32'b0;
        while (!status[4])
            axi_read(`UART_ADDR_STATUS, status);
        repeat (2) step();
    endtask

    // Samples tx near the centre of every bit, counted from the falling edge
    task automatic monitor_frame(input logic [31:0] ctrl, input logic [8:0] word);
        int baud;
        int i;
        baud = int'(ctrl[23:0]);
        @(negedge tx);
        repeat (baud / 2) @(negedge clk);
        check_equal("tx start bit", tx, 0);
        for (i = 0; i < word_length(ctrl); i++) begin
            repeat (baud) @(negedge clk);
            check_equal($sformatf("tx data bit %0d", i), tx, word[i]);
        end
        if (ctrl[28:27] != `UART_PARITY_NONE) begin
            repeat (baud) @(negedge clk);
            check_equal("tx parity bit", tx, parity_bit(ctrl, word));
        end
        repeat (baud) @(negedge clk);
        check_equal("tx stop bit", tx, 1);
        // The line stays high up to the end of the stop time
        repeat (stop_cycles(ctrl) - baud / 2) begin
            @(negedge clk);
            check_equal("tx stop time", tx, 1);
        end
    endtask

    task automatic hold_line(input logic value, input int cycles);
        rx = value;
        repeat (cycles) step();
    endtask

    task automatic drive_frame(input logic [31:0] ctrl, input logic [8:0] word,
                               input logic bad_parity, input logic bad_stop);
        int baud;
        int i;
        baud = int'(ctrl[23:0]);
        hold_line(1'b0, baud);
        for (i = 0; i < word_length(ctrl); i++)
            hold_line(word[i], baud);
        if (ctrl[28:27] != `UART_PARITY_NONE)
            hold_line(parity_bit(ctrl, word) ^ bad_parity, baud);
        // A broken frame pulls the first stop bit low
        if (bad_stop)
            hold_line(1'b0, baud);
        hold_line(1'b1, stop_cycles(ctrl) + baud);
    endtask

    task automatic test_registers();
        logic [31:0] value;
        logic [31:0] got;
        int n;
        axi_read(`UART_ADDR_STATUS, got);
        check_equal("STATUS after reset", got, 32'h0000_1010);
        for (n = 0; n < 4; n++) begin
            value = (n == 0) ? 32'hffff_ffff : next_random();
            axi_write(`UART_ADDR_CTRL, value);
            axi_read(`UART_ADDR_CTRL, got);
            check_equal("CTRL", got, value);
        end
        axi_write(32'h0000_0002, next_random());
        axi_read(`UART_ADDR_CTRL, got);
        check_equal("CTRL after unused write", got, value);
        axi_read(32'h0000_0002, got);
        check_equal("unused register", got, 0);
    endtask

    task automatic test_transmit(input logic [31:0] ctrl);
        logic [8:0] words [6];
        int i;
        int j;
        for (i = 0; i < 6; i++)
            words[i] = random_word();
        axi_write(`UART_ADDR_CTRL, ctrl);
        fork
            begin
                for (i = 0; i < 6; i++)
                    axi_write(`UART_ADDR_TXDATA, {23'b0, words[i]});
            end
            begin
                for (j = 0; j < 6; j++)
                    monitor_frame(ctrl, words[j]);
            end
        join
        wait_tx_idle();
    endtask

    task automatic test_receive(input logic [31:0] ctrl);
        logic [8:0]  words [4];
        logic [31:0] got;
        int i;
        axi_write(`UART_ADDR_CTRL, ctrl);
        for (i = 0; i < 4; i++) begin
            words[i] = random_word();
            drive_frame(ctrl, words[i], 1'b0, 1'b0);
        end
        for (i = 0; i < 4; i++) begin
            axi_read(`UART_ADDR_RXDATA, got);
            check_equal("RXDATA", got, {1'b1, 20'b0, 2'b00, words[i] & word_mask(ctrl)});
        end
        axi_read(`UART_ADDR_RXDATA, got);
        check_equal("RXDATA valid on empty FIFO", got[31], 0);
    endtask

    task automatic test_errors();
        logic [31:0] ctrl;
        logic [31:0] got;
        logic [8:0]  w0;
        logic [8:0]  w1;
        ctrl = make_ctrl(3'd3, `UART_PARITY_EVEN, `UART_STOP_BITS_1, `UART_FLOW_CTRL_OFF, BAUD);
        w0   = random_word();
        w1   = random_word();
        axi_write(`UART_ADDR_CTRL, ctrl);
        drive_frame(ctrl, w0, 1'b1, 1'b0);
        drive_frame(ctrl, w1, 1'b0, 1'b1);
        axi_read(`UART_ADDR_RXDATA, got);
        check_equal("RXDATA with parity error", got, {1'b1, 20'b0, 2'b01, w0 & 9'h0ff});
        axi_read(`UART_ADDR_RXDATA, got);
        check_equal("RXDATA with framing error", got, {1'b1, 20'b0, 2'b10, w1 & 9'h0ff});
    endtask

    task automatic test_flow_control();
        logic [8:0]  words [10];
        logic [31:0] ctrl;
        logic [31:0] got;
        int i;
        ctrl = make_ctrl(3'd3, `UART_PARITY_NONE, `UART_STOP_BITS_1, `UART_FLOW_CTRL_ON, BAUD);
        cts  = 1'b1;
        axi_write(`UART_ADDR_CTRL, ctrl);
        for (i = 0; i < 10; i++) begin
            words[i] = random_word();
            axi_write(`UART_ADDR_TXDATA, {23'b0, words[i]});
            check_equal("tx held by cts", tx, 1);
        end
        axi_read(`UART_ADDR_STATUS, got);
        check_equal("STATUS with full tx FIFO", got, 32'h0000_1028);
        repeat (2 * MAX_FRAME_CYCLES) begin
            step();
            check_equal("tx held by cts", tx, 1);
        end
        cts = 1'b0;
        // Only the eight words that fit in the FIFO may appear
        for (i = 0; i < 8; i++)
            monitor_frame(ctrl, words[i]);
        wait_tx_idle();
        repeat (MAX_FRAME_CYCLES) begin
            step();
            check_equal("tx idle after last word", tx, 1);
        end
    endtask

    initial begin
        n_reset = 1'b0;
        awaddr  = 32'b0;
        awvalid = 1'b0;
        wdata   = 32'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = 32'b0;
        arvalid = 1'b0;
        rready  = 1'b1;
        rx      = 1'b1;
        cts     = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        n_reset = 1'b1;

        test_registers();
        test_transmit(make_ctrl(3'd3, `UART_PARITY_NONE, `UART_STOP_BITS_1, 1'b0, BAUD));
        test_transmit(make_ctrl(3'd2, `UART_PARITY_EVEN, `UART_STOP_BITS_1, 1'b0, BAUD));
        test_transmit(make_ctrl(3'd4, `UART_PARITY_ODD, `UART_STOP_BITS_2, 1'b0, BAUD));
        test_transmit(make_ctrl(3'd0, `UART_PARITY_NONE, `UART_STOP_BITS_15, 1'b0, BAUD));
        test_receive(make_ctrl(3'd3, `UART_PARITY_NONE, `UART_STOP_BITS_1, 1'b0, BAUD));
        test_receive(make_ctrl(3'd2, `UART_PARITY_EVEN, `UART_STOP_BITS_1, 1'b0, BAUD));
        test_receive(make_ctrl(3'd4, `UART_PARITY_ODD, `UART_STOP_BITS_2, 1'b0, BAUD));
        test_receive(make_ctrl(3'd0, `UART_PARITY_NONE, `UART_STOP_BITS_15, 1'b0, BAUD));
        test_errors();
        test_flow_control();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- hdl/uart_top.sv
// ##################################################
// UART top level
// Register slave, two FIFOs and the line engines
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_top (
    input  logic        clk,
    input  logic        n_reset,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    output logic        tx,
    input  logic        rx,
    input  logic        cts
);

    import uart_pkg::*;

    logic [31:0]                     ctrl;
    logic                            tx_push;
    tx_word_t                        tx_data;
    tx_word_t                        tx_word;
    logic                            tx_pop;
    logic [`UART_FIFO_ADDR_WIDTH:0]  tx_size;
    logic                            tx_empty;
    logic                            tx_full;
    logic                            rx_push;
    rx_entry_t                       rx_entry;
    rx_entry_t                       rx_head;
    logic                            rx_pop;
    logic [`UART_FIFO_ADDR_WIDTH:0]  rx_size;
    logic                            rx_empty;
    logic                            rx_full;

    uart_axil_regs regs0 (
        .clk(clk), .n_reset(n_reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .ctrl(ctrl),
        .tx_push(tx_push), .tx_data(tx_data),
        .tx_size(tx_size), .tx_empty(tx_empty), .tx_full(tx_full),
        .rx_pop(rx_pop), .rx_head(rx_head),
        .rx_size(rx_size), .rx_empty(rx_empty), .rx_full(rx_full)
    );

    // The register slave fills the transmit FIFO and the serializer drains it
    uart_fifo #(.ADDR_WIDTH(`UART_FIFO_ADDR_WIDTH), .payload_t(tx_word_t)) tx_fifo (
        .clk(clk), .n_reset(n_reset),
        .push(tx_push), .data_in(tx_data),
        .pop(tx_pop), .data_out(tx_word),
        .size(tx_size), .empty(tx_empty), .full(tx_full)
    );

    uart_tx tx0 (
        .clk(clk), .n_reset(n_reset),
        .tx(tx), .cts(cts), .ctrl(ctrl),
        .word(tx_word), .empty(tx_empty), .pop(tx_pop)
    );

    // The deserializer fills the receive FIFO and the register slave drains it
    uart_rx rx0 (
        .clk(clk), .n_reset(n_reset),
        .rx(rx), .ctrl(ctrl),
        .push(rx_push), .entry(rx_entry)
    );

    uart_fifo #(.ADDR_WIDTH(`UART_FIFO_ADDR_WIDTH), .payload_t(rx_entry_t)) rx_fifo (
        .clk(clk), .n_reset(n_reset),
        .push(rx_push), .data_in(rx_entry),
        .pop(rx_pop), .data_out(rx_head),
        .size(rx_size), .empty(rx_empty), .full(rx_full)
    );

endmodule

//--- hdl/uart_rx.sv
// ##################################################
// UART receive deserializer
// Samples rx mid-bit and pushes checked entries
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx (
    input  logic                clk,
    input  logic                n_reset,
    input  logic                rx,
    input  logic [31:0]         ctrl,
    output logic                push,
    output uart_pkg::rx_entry_t entry
);

    localparam logic [4:0] IDLE   = 5'b00001;
    localparam logic [4:0] START  = 5'b00010;
    localparam logic [4:0] DATA   = 5'b00100;
    localparam logic [4:0] PARITY = 5'b01000;
    localparam logic [4:0] STOP   = 5'b10000;

    logic [2:0]  data_bits;
    logic [1:0]  parity;
    logic [23:0] baud_reg;
    logic [3:0]  n_bits;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic [4:0]  state;
    logic [23:0] counter;
    logic [3:0]  bit_idx;
    logic        bit_done;
    logic        half_done;
    logic [8:0]  shreg;
    logic        par_bit;
    logic        par_expect;

    assign data_bits = ctrl[31:29];
    assign parity    = ctrl[28:27];
    assign baud_reg  = ctrl[23:0];
    assign n_bits    = (data_bits > 3'd4) ? 4'd9 : {1'b0, data_bits} + 4'd5;
    assign bit_done  = counter == baud_reg - 24'd1;
    assign half_done = counter == {1'b0, baud_reg[23:1]} - 24'd1;

    // Unused upper bits of shreg are zero, so the XOR covers the active bits only
    assign par_expect = (parity == `UART_PARITY_ODD) ? ~^shreg : ^shreg;

    // Entry goes out in the middle of the first stop bit
    assign push = state == STOP && bit_done;

    always_comb begin
        entry.data       = shreg;
        entry.parity_err = parity != `UART_PARITY_NONE && par_bit != par_expect;
        entry.frame_err  = !rx_sync;
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            state   <= IDLE;
            counter <= 24'd0;
            bit_idx <= 4'd0;
        end else begin
            counter <= counter + 24'd1;
            case (state)
                IDLE: begin
                    counter <= 24'd0;
                    bit_idx <= 4'd0;
                    if (rx_prev && !rx_sync)
                        state <= START;
                end
                START: begin
                    // A line that is high again at half a bit was only a glitch
                    if (half_done) begin
                        counter <= 24'd0;
                        state   <= rx_sync ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        counter <= 24'd0;
                        bit_idx <= bit_idx + 4'd1;
                        if (bit_idx == n_bits - 4'd1)
                            state <= (parity == `UART_PARITY_NONE) ? STOP : PARITY;
                    end
                end
                PARITY: begin
                    if (bit_done) begin
                        counter <= 24'd0;
                        state   <= STOP;
                    end
                end
                STOP: begin
                    if (bit_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE)
            shreg <= 9'b0;
        else if (state == DATA && bit_done)
            shreg[bit_idx] <= rx_sync;
        if (state == PARITY && bit_done)
            par_bit <= rx_sync;
    end

endmodule

//--- hdl/uart_tx.sv
// ##################################################
// UART transmit serializer
// Drains the tx FIFO onto the line, honours CTS
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tx (
    input  logic               clk,
    input  logic               n_reset,
    output logic               tx,
    input  logic               cts,
    input  logic [31:0]        ctrl,
    input  uart_pkg::tx_word_t word,
    input  logic               empty,
    output logic               pop
);

    localparam logic [4:0] IDLE   = 5'b00001;
    localparam logic [4:0] START  = 5'b00010;
    localparam logic [4:0] DATA   = 5'b00100;
    localparam logic [4:0] PARITY = 5'b01000;
    localparam logic [4:0] STOP   = 5'b10000;

    logic [2:0]  data_bits;
    logic [1:0]  parity;
    logic [1:0]  stop_bits;
    logic        flow_ctrl;
    logic [23:0] baud_reg;
    logic [3:0]  n_bits;
    logic [8:0]  active;
    logic        par_bit;
    logic [24:0] stop_len;
    logic        bit_done;
    logic        stop_done;
    logic        cts_meta;
    logic        cts_sync;
    logic [4:0]  state;
    logic [24:0] counter;
    logic [3:0]  bit_idx;

    assign {data_bits, parity, stop_bits, flow_ctrl, baud_reg} = ctrl;
    assign n_bits  = (data_bits > 3'd4) ? 4'd9 : {1'b0, data_bits} + 4'd5;
    // Parity only covers the bits that actually go out
    assign active  = word & (9'h1ff >> (4'd9 - n_bits));
    assign par_bit = (parity == `UART_PARITY_ODD) ? ~^active : ^active;

    always_comb begin
        case (stop_bits)
            `UART_STOP_BITS_15: stop_len = {1'b0, baud_reg} + {2'b0, baud_reg[23:1]};
            `UART_STOP_BITS_2:  stop_len = {baud_reg, 1'b0};
            default:            stop_len = {1'b0, baud_reg};
        endcase
    end

    assign bit_done  = counter == {1'b0, baud_reg} - 25'd1;
    assign stop_done = counter == stop_len - 25'd1;
    // The head word leaves the FIFO in the last cycle of the stop time
    assign pop       = state == STOP && stop_done;

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            cts_meta <= 1'b1;
            cts_sync <= 1'b1;
        end else begin
            cts_meta <= cts;
            cts_sync <= cts_meta;
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            tx      <= 1'b1;
            state   <= IDLE;
            counter <= 25'd0;
            bit_idx <= 4'd0;
        end else begin
            counter <= counter + 25'd1;
            case (state)
                IDLE: begin
                    counter <= 25'd0;
                    bit_idx <= 4'd0;
                    // CTS is only looked at here, so a frame never stops halfway
                    if (!empty && (flow_ctrl == `UART_FLOW_CTRL_OFF || !cts_sync)) begin
                        tx    <= 1'b0;
                        state <= START;
                    end
                end
                START: begin
                    if (bit_done) begin
                        counter <= 25'd0;
                        tx      <= word[0];
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        counter <= 25'd0;
                        if (bit_idx == n_bits - 4'd1) begin
                            tx    <= (parity == `UART_PARITY_NONE) ? 1'b1 : par_bit;
                            state <= (parity == `UART_PARITY_NONE) ? STOP : PARITY;
                        end else begin
                            bit_idx <= bit_idx + 4'd1;
                            tx      <= word[bit_idx + 4'd1];
                        end
                    end
                end
                PARITY: begin
                    if (bit_done) begin
                        counter <= 25'd0;
                        tx      <= 1'b1;
                        state   <= STOP;
                    end
                end
                STOP: begin
                    if (stop_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_pop_not_empty: assert property (@(posedge clk) disable iff (!n_reset)
        pop |-> !empty);

endmodule

//--- hdl/uart_axil_regs.sv
// ##################################################
// UART AXI4-Lite register slave
// Control, status and the FIFO data ports
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_axil_regs (
    input  logic                clk,
    input  logic                n_reset,
    input  logic [31:0]         awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  logic [31:0]         wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  logic [31:0]         araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic [31:0]         rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,
    output logic [31:0]         ctrl,
    output logic                tx_push,
    output uart_pkg::tx_word_t  tx_data,
    input  logic [3:0]          tx_size,
    input  logic                tx_empty,
    input  logic                tx_full,
    output logic                rx_pop,
    input  uart_pkg::rx_entry_t rx_head,
    input  logic [3:0]          rx_size,
    input  logic                rx_empty,
    input  logic                rx_full
);

    logic        wr_hs;
    logic        wr_accept;
    logic        rd_hs;
    logic [31:0] rd_mux;

    // Address and data are taken together, one transaction at a time
    assign wr_accept = awvalid && wvalid && !awready && !bvalid;
    assign wr_hs     = awready && awvalid && wvalid;
    assign arready   = !rvalid;
    assign rd_hs     = arvalid && arready;
    assign bresp     = 2'b00;
    assign rresp     = 2'b00;

    assign tx_push = wr_hs && awaddr[3:0] == `UART_ADDR_TXDATA && !tx_full;
    assign tx_data = wdata[8:0];
    assign rx_pop  = rd_hs && araddr[3:0] == `UART_ADDR_RXDATA && !rx_empty;

    always_comb begin
        case (araddr[3:0])
            `UART_ADDR_CTRL:   rd_mux = ctrl;
            `UART_ADDR_STATUS: rd_mux = {18'b0, rx_full, rx_empty, rx_size,
                                         2'b0, tx_full, tx_empty, tx_size};
            // Bit 31 tells the master whether the entry is real
            `UART_ADDR_RXDATA: rd_mux = {!rx_empty, 20'b0, rx_head};
            default:           rd_mux = 32'b0;
        endcase
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            ctrl    <= 32'b0;
        end else begin
            awready <= wr_accept;
            wready  <= wr_accept;
            if (wr_hs) begin
                bvalid <= 1'b1;
                if (awaddr[3:0] == `UART_ADDR_CTRL)
                    ctrl <= wdata;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset)
            rvalid <= 1'b0;
        else if (rd_hs)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // Read data is captured at the handshake and held until rready
    always_ff @(posedge clk) begin
        if (rd_hs)
            rdata <= rd_mux;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!n_reset)
        bvalid && !bready |=> bvalid);

endmodule

//--- hdl/uart_fifo.sv
// ##################################################
// Synchronous FIFO
// Circular buffer for any payload type
// ##################################################
`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_fifo #(
    parameter int  ADDR_WIDTH = `UART_FIFO_ADDR_WIDTH,
    parameter type payload_t  = logic [8:0]
) (
    input  logic                clk,
    input  logic                n_reset,
    input  logic                push,
    input  payload_t            data_in,
    input  logic                pop,
    output payload_t            data_out,
    output logic [ADDR_WIDTH:0] size,
    output logic                empty,
    output logic                full
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    payload_t              mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    // Pushes into a full FIFO and pops from an empty one are dropped
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = size == '0;
    assign full     = size == (ADDR_WIDTH + 1)'(DEPTH);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk or negedge n_reset) begin
        if (!n_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            size   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                size <= size + 1'b1;
            else if (do_pop && !do_push)
                size <= size - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

    // The count must stay within the buffer across any push and pop sequence
    a_size_bound: assert property (@(posedge clk) disable iff (!n_reset)
        size <= (ADDR_WIDTH + 1)'(DEPTH));

    // The pointers are always as far apart as the count says
    a_ptr_size: assert property (@(posedge clk) disable iff (!n_reset)
        wr_ptr - rd_ptr == size[ADDR_WIDTH-1:0]);

endmodule

//--- hdl/uart_pkg.sv
// ##################################################
// UART payload types
// Transmit words and receive FIFO entries
// ##################################################
package uart_pkg;

    // Data bits of one character, bit 0 goes out first
    typedef logic [8:0] tx_word_t;

    // One received character with its error flags
    // Packed so that data sits in bits 8:0 and frame_err in bit 10
    typedef struct packed {
        logic       frame_err;
        logic       parity_err;
        logic [8:0] data;
    } rx_entry_t;

endpackage

//--- hdl/uart_defines.svh
// ##################################################
// UART shared constants
// Register offsets, control field codes, FIFO depth
// ##################################################
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Register map, decoded on the low address nibble
`define UART_ADDR_CTRL      4'h0
`define UART_ADDR_STATUS    4'h4
`define UART_ADDR_TXDATA    4'h8
`define UART_ADDR_RXDATA    4'hc

`define UART_PARITY_NONE    2'b00
`define UART_PARITY_EVEN    2'b01
`define UART_PARITY_ODD     2'b10

`define UART_STOP_BITS_1    2'b00
`define UART_STOP_BITS_15   2'b01
`define UART_STOP_BITS_2    2'b10

`define UART_FLOW_CTRL_OFF  1'b0
`define UART_FLOW_CTRL_ON   1'b1

// Eight entries per FIFO
`define UART_FIFO_ADDR_WIDTH 3

`endif
